//--- droute_cfg_pkg.sv
/*
 * Datapath configuration for the stream router.
 * Default beat width, packing factor and command count width.
 */

package droute_cfg_pkg;

	// narrow beat of stream a.
	parameter int NARROW_W_DEF = 32;

	// narrow beats per wide word.
	parameter int PACK_DEF = 4;

	// wide word as seen by the switches and merges.
	parameter int WIDE_W_DEF = NARROW_W_DEF * PACK_DEF;

	// word count carried by a route command.
	parameter int CNT_W_DEF = 8;

endpackage

//--- droute_cmd_pkg.sv
/*
 * Route command encodings.
 * Sources, destinations and switch control states.
 */

package droute_cmd_pkg;

	// stream a enters through the beat packer.
	typedef enum logic [1:0] {
		SRC_A = 2'd0,
		SRC_C = 2'd1,
		SRC_D = 2'd2
	} route_src_t;

	typedef enum logic {
		DST_X = 1'b0,
		DST_Y = 1'b1
	} route_dst_t;

	// done lasts one cycle, then back to idle.
	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_RUN  = 2'd1,
		ST_DONE = 2'd2
	} route_state_t;

endpackage

//--- beat_packer.sv
/*
 * Beat packer for stream A.
 * Collects PACK narrow beats, or fewer up to last, into one zero-filled wide word.
 */

`timescale 1ns/1ps

module beat_packer import droute_cfg_pkg::*; #(
	parameter int NARROW_W = NARROW_W_DEF,
	parameter int PACK     = PACK_DEF,
	parameter int WIDE_W   = WIDE_W_DEF
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [NARROW_W-1:0] in_data,
	input  logic                in_valid,
	output logic                in_ready,
	input  logic                in_last,
	output logic [WIDE_W-1:0]   wide_data,
	output logic                wide_valid,
	input  logic                wide_ready
);

	localparam int IDX_W = (PACK > 1) ? $clog2(PACK) : 1;

	logic [IDX_W-1:0]  idx;
	logic [WIDE_W-1:0] word_q;
	logic              beat_take;
	logic              word_close;

	// a held word blocks new beats until it leaves.
	assign in_ready   = !wide_valid || wide_ready;
	assign beat_take  = in_valid && in_ready;
	assign word_close = in_last || (idx == IDX_W'(PACK - 1));
	assign wide_data  = word_q;

	always_ff @(posedge clk) begin
		if (beat_take) begin
			if (idx == '0)
				word_q <= WIDE_W'(in_data);
			else
				word_q[idx*NARROW_W +: NARROW_W] <= in_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_n) begin
			idx        <= '0;
			wide_valid <= 1'b0;
		end else begin
			if (wide_valid && wide_ready)
				wide_valid <= 1'b0;
			if (beat_take) begin
				if (word_close) begin
					idx        <= '0;
					wide_valid <= 1'b1;
				end else begin
					idx <= idx + 1'b1;
				end
			end
		end
	end

endmodule

//--- route_fsm.sv
/*
 * Command FSM of one route switch.
 * Takes a command, runs until the last word moves, then flags done for one cycle.
 */

`timescale 1ns/1ps

module route_fsm import droute_cmd_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic cmd_valid,
	input  logic xfer,
	input  logic last_word,
	output logic cmd_ready,
	output logic cmd_done,
	output logic load,
	output logic running
);

	route_state_t state;
	route_state_t state_nxt;

	assign cmd_ready = (state == ST_IDLE);
	assign load      = cmd_valid && cmd_ready;
	assign running   = (state == ST_RUN);
	assign cmd_done  = (state == ST_DONE);

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (load)
					state_nxt = ST_RUN;
			end
			ST_RUN: begin
				// the word moving now is the last one of the command.
				if (xfer && last_word)
					state_nxt = ST_DONE;
			end
			ST_DONE: begin
				state_nxt = ST_IDLE;
			end
			default: begin
				state_nxt = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_n)
			state <= ST_IDLE;
		else
			state <= state_nxt;
	end

endmodule

//--- word_counter.sv
/*
 * Remaining-word counter of one route switch.
 * Loads the command count and marks the final word.
 */

`timescale 1ns/1ps

module word_counter import droute_cfg_pkg::*; #(
	parameter int CNT_W = CNT_W_DEF
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             load,
	input  logic [CNT_W-1:0] load_value,
	input  logic             step,
	output logic             last_word
);

	logic [CNT_W-1:0] remaining;

	// counts are never zero, so one left means this is the last word.
	assign last_word = (remaining == CNT_W'(1));

	always_ff @(posedge clk) begin
		if (rst_n)
			remaining <= '0;
		else if (load)
			remaining <= load_value;
		else if (step)
			remaining <= remaining - 1'b1;
	end

endmodule

//--- route_switch.sv
/*
 * Route switch.
 * Connects one source to one destination for a commanded number of wide words.
 */

`timescale 1ns/1ps

module route_switch import droute_cfg_pkg::*, droute_cmd_pkg::*; #(
	parameter int WIDE_W = WIDE_W_DEF,
	parameter int CNT_W  = CNT_W_DEF
) (
	input  logic              clk,
	input  logic              rst_n,
	input  route_src_t        cmd_src,
	input  route_dst_t        cmd_dst,
	input  logic [CNT_W-1:0]  cmd_count,
	input  logic              cmd_valid,
	output logic              cmd_ready,
	output logic              cmd_done,
	input  logic [WIDE_W-1:0] a_data,
	input  logic              a_valid,
	output logic              a_ready,
	input  logic [WIDE_W-1:0] c_data,
	input  logic              c_valid,
	output logic              c_ready,
	input  logic [WIDE_W-1:0] d_data,
	input  logic              d_valid,
	output logic              d_ready,
	output logic [WIDE_W-1:0] route_data,
	output logic              route_valid_x,
	output logic              route_valid_y,
	input  logic              ready_x,
	input  logic              ready_y
);

	route_src_t        src_q;
	route_dst_t        dst_q;
	logic              load;
	logic              running;
	logic              last_word;
	logic              xfer;
	logic              sel_valid;
	logic              dst_ready;
	logic              grant;

	route_fsm u_fsm (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd_valid (cmd_valid),
		.xfer      (xfer),
		.last_word (last_word),
		.cmd_ready (cmd_ready),
		.cmd_done  (cmd_done),
		.load      (load),
		.running   (running)
	);

	word_counter #(
		.CNT_W (CNT_W)
	) u_cnt (
		.clk        (clk),
		.rst_n      (rst_n),
		.load       (load),
		.load_value (cmd_count),
		.step       (xfer),
		.last_word  (last_word)
	);

	always_ff @(posedge clk) begin
		if (rst_n) begin
			src_q <= SRC_A;
			dst_q <= DST_X;
		end else if (load) begin
			src_q <= cmd_src;
			dst_q <= cmd_dst;
		end
	end

	always_comb begin
		route_data = a_data;
		sel_valid  = a_valid;
		case (src_q)
			SRC_C: begin
				route_data = c_data;
				sel_valid  = c_valid;
			end
			SRC_D: begin
				route_data = d_data;
				sel_valid  = d_valid;
			end
			default: begin
				route_data = a_data;
				sel_valid  = a_valid;
			end
		endcase
	end

	// nothing moves outside the run state.
	assign route_valid_x = running && sel_valid && (dst_q == DST_X);
	assign route_valid_y = running && sel_valid && (dst_q == DST_Y);

	assign dst_ready = (dst_q == DST_X) ? ready_x : ready_y;
	assign grant     = running && dst_ready;
	assign a_ready   = grant && (src_q == SRC_A);
	assign c_ready   = grant && (src_q == SRC_C);
	assign d_ready   = grant && (src_q == SRC_D);
	assign xfer      = grant && sel_valid;

endmodule

//--- stream_merge.sv
/*
 * Two-input merge into one registered output.
 * Input 0 wins when both are valid; the register stalls under back-pressure.
 */

`timescale 1ns/1ps

module stream_merge import droute_cfg_pkg::*; #(
	parameter int WIDE_W = WIDE_W_DEF
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [WIDE_W-1:0] in0_data,
	input  logic              in0_valid,
	output logic              in0_ready,
	input  logic [WIDE_W-1:0] in1_data,
	input  logic              in1_valid,
	output logic              in1_ready,
	output logic [WIDE_W-1:0] out_data,
	output logic              out_valid,
	input  logic              out_ready
);

	logic can_take;

	// empty now, or emptied in this same cycle.
	assign can_take  = !out_valid || out_ready;
	assign in0_ready = can_take;
	assign in1_ready = can_take && !in0_valid;

	always_ff @(posedge clk) begin
		if (can_take) begin
			if (in0_valid)
				out_data <= in0_data;
			else if (in1_valid)
				out_data <= in1_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_n)
			out_valid <= 1'b0;
		else if (can_take)
			out_valid <= in0_valid || in1_valid;
	end

endmodule

//--- droute.sv
/*
 * Stream router top level.
 * Packs stream A, routes A, C and D through two command switches to outputs X and Y.
 */

`timescale 1ns/1ps

module droute import droute_cfg_pkg::*, droute_cmd_pkg::*; #(
	parameter int  NARROW_W = NARROW_W_DEF,
	parameter int  PACK     = PACK_DEF,
	parameter int  CNT_W    = CNT_W_DEF,
	localparam int WIDE_W   = NARROW_W * PACK
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [NARROW_W-1:0] in_a_data,
	input  logic                in_a_valid,
	output logic                in_a_ready,
	input  logic                in_a_last,
	input  logic [WIDE_W-1:0]   in_c_data,
	input  logic                in_c_valid,
	output logic                in_c_ready,
	input  logic [WIDE_W-1:0]   in_d_data,
	input  logic                in_d_valid,
	output logic                in_d_ready,
	input  route_src_t          cmd0_src,
	input  route_dst_t          cmd0_dst,
	input  logic [CNT_W-1:0]    cmd0_count,
	input  logic                cmd0_valid,
	output logic                cmd0_ready,
	output logic                cmd0_done,
	input  route_src_t          cmd1_src,
	input  route_dst_t          cmd1_dst,
	input  logic [CNT_W-1:0]    cmd1_count,
	input  logic                cmd1_valid,
	output logic                cmd1_ready,
	output logic                cmd1_done,
	output logic [WIDE_W-1:0]   out_x_data,
	output logic                out_x_valid,
	input  logic                out_x_ready,
	output logic [WIDE_W-1:0]   out_y_data,
	output logic                out_y_valid,
	input  logic                out_y_ready
);

	logic [WIDE_W-1:0] a_data;
	logic              a_valid;
	logic              a_ready0, a_ready1;
	logic              c_ready0, c_ready1;
	logic              d_ready0, d_ready1;
	logic [WIDE_W-1:0] route_data0, route_data1;
	logic              valid_x0, valid_y0, valid_x1, valid_y1;
	logic              ready_x0, ready_y0, ready_x1, ready_y1;

	// only one switch uses a given source at a time.
	assign in_c_ready = c_ready0 | c_ready1;
	assign in_d_ready = d_ready0 | d_ready1;

	beat_packer #(
		.NARROW_W (NARROW_W),
		.PACK     (PACK),
		.WIDE_W   (WIDE_W)
	) u_pack (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_data    (in_a_data),
		.in_valid   (in_a_valid),
		.in_ready   (in_a_ready),
		.in_last    (in_a_last),
		.wide_data  (a_data),
		.wide_valid (a_valid),
		.wide_ready (a_ready0 | a_ready1)
	);

	route_switch #(
		.WIDE_W (WIDE_W),
		.CNT_W  (CNT_W)
	) sw0 (
		.clk           (clk),
		.rst_n         (rst_n),
		.cmd_src       (cmd0_src),
		.cmd_dst       (cmd0_dst),
		.cmd_count     (cmd0_count),
		.cmd_valid     (cmd0_valid),
		.cmd_ready     (cmd0_ready),
		.cmd_done      (cmd0_done),
		.a_data        (a_data),
		.a_valid       (a_valid),
		.a_ready       (a_ready0),
		.c_data        (in_c_data),
		.c_valid       (in_c_valid),
		.c_ready       (c_ready0),
		.d_data        (in_d_data),
		.d_valid       (in_d_valid),
		.d_ready       (d_ready0),
		.route_data    (route_data0),
		.route_valid_x (valid_x0),
		.route_valid_y (valid_y0),
		.ready_x       (ready_x0),
		.ready_y       (ready_y0)
	);

	route_switch #(
		.WIDE_W (WIDE_W),
		.CNT_W  (CNT_W)
	) sw1 (
		.clk           (clk),
		.rst_n         (rst_n),
		.cmd_src       (cmd1_src),
		.cmd_dst       (cmd1_dst),
		.cmd_count     (cmd1_count),
		.cmd_valid     (cmd1_valid),
		.cmd_ready     (cmd1_ready),
		.cmd_done      (cmd1_done),
		.a_data        (a_data),
		.a_valid       (a_valid),
		.a_ready       (a_ready1),
		.c_data        (in_c_data),
		.c_valid       (in_c_valid),
		.c_ready       (c_ready1),
		.d_data        (in_d_data),
		.d_valid       (in_d_valid),
		.d_ready       (d_ready1),
		.route_data    (route_data1),
		.route_valid_x (valid_x1),
		.route_valid_y (valid_y1),
		.ready_x       (ready_x1),
		.ready_y       (ready_y1)
	);

	// switch 0 always sits on the priority input.
	stream_merge #(
		.WIDE_W (WIDE_W)
	) merge_x (
		.clk       (clk),
		.rst_n     (rst_n),
		.in0_data  (route_data0),
		.in0_valid (valid_x0),
		.in0_ready (ready_x0),
		.in1_data  (route_data1),
		.in1_valid (valid_x1),
		.in1_ready (ready_x1),
		.out_data  (out_x_data),
		.out_valid (out_x_valid),
		.out_ready (out_x_ready)
	);

	stream_merge #(
		.WIDE_W (WIDE_W)
	) merge_y (
		.clk       (clk),
		.rst_n     (rst_n),
		.in0_data  (route_data0),
		.in0_valid (valid_y0),
		.in0_ready (ready_y0),
		.in1_data  (route_data1),
		.in1_valid (valid_y1),
		.in1_ready (ready_y1),
		.out_data  (out_y_data),
		.out_valid (out_y_valid),
		.out_ready (out_y_ready)
	);

endmodule

//--- droute_tb_assert.sv
/*
 * Concurrent assertions for the stream router, bound into droute.
 * Output hold rules, one-cycle done and command ready in the run state.
 */

`timescale 1ns/1ps

module droute_tb_assert import droute_cfg_pkg::*, droute_cmd_pkg::*; #(
	parameter int WIDE_W = WIDE_W_DEF
) (
	input logic              clk,
	input logic              rst_n,
	input logic [WIDE_W-1:0] out_x_data,
	input logic              out_x_valid,
	input logic              out_x_ready,
	input logic [WIDE_W-1:0] out_y_data,
	input logic              out_y_valid,
	input logic              out_y_ready,
	input logic              cmd0_valid,
	input logic              cmd0_ready,
	input logic              cmd0_done,
	input logic              cmd1_valid,
	input logic              cmd1_ready,
	input logic              cmd1_done,
	input route_state_t      state0,
	input route_state_t      state1
);

	// the testbench polls this count of failed assertions.
	int fail_cnt = 0;

	x_hold: assert property (@(posedge clk) disable iff (rst_n)
		out_x_valid && !out_x_ready |=> out_x_valid && $stable(out_x_data))
		else begin
			fail_cnt++;
			$error("out_x_valid dropped or out_x_data changed before ready");
		end

	y_hold: assert property (@(posedge clk) disable iff (rst_n)
		out_y_valid && !out_y_ready |=> out_y_valid && $stable(out_y_data))
		else begin
			fail_cnt++;
			$error("out_y_valid dropped or out_y_data changed before ready");
		end

	done0_pulse: assert property (@(posedge clk) disable iff (rst_n)
		cmd0_done |=> !cmd0_done)
		else begin
			fail_cnt++;
			$error("cmd0_done held for more than one cycle");
		end

	done1_pulse: assert property (@(posedge clk) disable iff (rst_n)
		cmd1_done |=> !cmd1_done)
		else begin
			fail_cnt++;
			$error("cmd1_done held for more than one cycle");
		end

	// a taken command puts the switch in the run state with ready low.
	run0_busy: assert property (@(posedge clk) disable iff (rst_n)
		cmd0_valid && cmd0_ready |=> state0 == ST_RUN && !cmd0_ready)
		else begin
			fail_cnt++;
			$error("switch 0 not running with cmd0_ready low after a command");
		end

	run1_busy: assert property (@(posedge clk) disable iff (rst_n)
		cmd1_valid && cmd1_ready |=> state1 == ST_RUN && !cmd1_ready)
		else begin
			fail_cnt++;
			$error("switch 1 not running with cmd1_ready low after a command");
		end

endmodule

//--- droute_tb.sv
/*
 * Testbench for the stream router.
 * Random routing rounds checked against one expected queue per switch.
 */

`timescale 1ns/1ps

module droute_tb
	import droute_cfg_pkg::*, droute_cmd_pkg::*;
();

	localparam int NARROW_W   = NARROW_W_DEF;
	localparam int PACK       = PACK_DEF;
	localparam int CNT_W      = CNT_W_DEF;
	localparam int WIDE_W     = NARROW_W * PACK;
	localparam int ROUNDS     = 40;
	localparam int CLK_PERIOD = 40;

	logic                clk;
	logic                rst_n;
	logic [NARROW_W-1:0] in_a_data;
	logic                in_a_valid, in_a_ready, in_a_last;
	logic [WIDE_W-1:0]   in_c_data, in_d_data;
	logic                in_c_valid, in_c_ready, in_d_valid, in_d_ready;
	route_src_t          cmd0_src, cmd1_src;
	route_dst_t          cmd0_dst, cmd1_dst;
	logic [CNT_W-1:0]    cmd0_count, cmd1_count;
	logic                cmd0_valid, cmd0_ready, cmd0_done;
	logic                cmd1_valid, cmd1_ready, cmd1_done;
	logic [WIDE_W-1:0]   out_x_data, out_y_data;
	logic                out_x_valid, out_x_ready, out_y_valid, out_y_ready;

	logic [31:0]         rng_state;
	int                  err_cnt;
	route_src_t          src_r [2];
	route_dst_t          dst_r [2];
	bit                  done_r [2];
	bit                  ready_due [2];
	logic [WIDE_W-1:0]   exp_q [2][$];
	logic [WIDE_W-1:0]   c_q [$];
	logic [WIDE_W-1:0]   d_q [$];
	logic [NARROW_W-1:0] a_q [$];
	logic                a_last_q [$];

	droute #(
		.NARROW_W (NARROW_W),
		.PACK     (PACK),
		.CNT_W    (CNT_W)
	) dut (.*);

	bind droute droute_tb_assert #(
		.WIDE_W (WIDE_W)
	) u_assert (
		.clk         (clk),
		.rst_n       (rst_n),
		.out_x_data  (out_x_data),
		.out_x_valid (out_x_valid),
		.out_x_ready (out_x_ready),
		.out_y_data  (out_y_data),
		.out_y_valid (out_y_valid),
		.out_y_ready (out_y_ready),
		.cmd0_valid  (cmd0_valid),
		.cmd0_ready  (cmd0_ready),
		.cmd0_done   (cmd0_done),
		.cmd1_valid  (cmd1_valid),
		.cmd1_ready  (cmd1_ready),
		.cmd1_done   (cmd1_done),
		.state0      (sw0.u_fsm.state),
		.state1      (sw1.u_fsm.state)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		// low bits of an lcg repeat quickly so the upper half leads.
		return {rng_state[15:0], rng_state[31:16]};
	endfunction

	function automatic int src_pending(input route_src_t src);
		case (src)
			SRC_A:   return a_q.size();
			SRC_C:   return c_q.size();
			default: return d_q.size();
		endcase
	endfunction

	task automatic stop_run();
		$display("Checks failed");
		$fatal(1, "droute_tb stopped at the first error");
	endtask

	task automatic fail_with_reason(input string why);
		$display("%s", why);
		err_cnt++;
		stop_run();
	endtask

	task automatic check_word(input string name, input logic [WIDE_W-1:0] got,
			input logic [WIDE_W-1:0] exp);
		if (got !== exp) begin
			$display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
			err_cnt++;
			stop_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
			err_cnt++;
			stop_run();
		end
	endtask

	// the word must be the next one of a switch that targets this output.
	task automatic match_output(input string name, input route_dst_t dst,
			input logic [WIDE_W-1:0] data);
		bit hit;
		hit = 1'b0;
		for (int n = 0; n < 2; n++) begin
			if (!hit && dst_r[n] == dst && exp_q[n].size() > 0 && exp_q[n][0] == data) begin
				void'(exp_q[n].pop_front());
				hit = 1'b1;
			end
		end
		if (!hit) begin
			for (int n = 0; n < 2; n++)
				if (dst_r[n] == dst && exp_q[n].size() > 0)
					check_word(name, data, exp_q[n][0]);
			fail_with_reason($sformatf("an unexpected word 0x%h came out on %s", data, name));
		end
	endtask

	task automatic check_done(input int n, input logic done, input logic ready);
		if (ready_due[n]) begin
			check_flag($sformatf("cmd%0d_ready", n), ready, 1'b1);
			ready_due[n] = 1'b0;
		end
		if (done === 1'b1) begin
			if (done_r[n])
				fail_with_reason($sformatf("cmd%0d_done pulsed twice for one command", n));
			if (src_pending(src_r[n]) != 0)
				fail_with_reason($sformatf("cmd%0d_done came before all source words left", n));
			done_r[n] = 1'b1;
			ready_due[n] = 1'b1;
		end
	endtask

	task automatic next_cycle();
		bit go;
		@(posedge clk);
		if (dut.u_assert.fail_cnt != 0)
			fail_with_reason("a concurrent assertion on droute failed");
		if (out_x_valid && out_x_ready)
			match_output("out_x_data", DST_X, out_x_data);
		if (out_y_valid && out_y_ready)
			match_output("out_y_data", DST_Y, out_y_data);
		check_done(0, cmd0_done, cmd0_ready);
		check_done(1, cmd1_done, cmd1_ready);
		if (cmd0_valid && cmd0_ready)
			cmd0_valid <= 1'b0;
		if (cmd1_valid && cmd1_ready)
			cmd1_valid <= 1'b0;
		if (in_a_valid && in_a_ready) begin
			void'(a_q.pop_front());
			void'(a_last_q.pop_front());
		end
		if (in_c_valid && in_c_ready)
			void'(c_q.pop_front());
		if (in_d_valid && in_d_ready)
			void'(d_q.pop_front());
		// a word not yet taken stays on its bus unchanged.
		if (!(in_a_valid && !in_a_ready)) begin
			go = a_q.size() > 0 && lcg_next() % 8 != 0;
			in_a_valid <= go;
			if (go) begin
				in_a_data <= a_q[0];
				in_a_last <= a_last_q[0];
			end
		end
		if (!(in_c_valid && !in_c_ready)) begin
			go = c_q.size() > 0 && lcg_next() % 8 != 0;
			in_c_valid <= go;
			if (go)
				in_c_data <= c_q[0];
		end
		if (!(in_d_valid && !in_d_ready)) begin
			go = d_q.size() > 0 && lcg_next() % 8 != 0;
			in_d_valid <= go;
			if (go)
				in_d_data <= d_q[0];
		end
		out_x_ready <= lcg_next() % 4 != 0;
		out_y_ready <= lcg_next() % 4 != 0;
	endtask

	task automatic run_round();
		logic [31:0]         r;
		logic [WIDE_W-1:0]   w;
		logic [NARROW_W-1:0] beat;
		int                  s0;
		int                  cnt;
		int                  beats;
		r = lcg_next();
		s0 = int'(r % 3);
		src_r[0] = route_src_t'(2'(s0));
		src_r[1] = route_src_t'(2'((s0 + 1 + int'(r[8])) % 3));
		for (int n = 0; n < 2; n++) begin
			r = lcg_next();
			dst_r[n] = r[4] ? DST_Y : DST_X;
			cnt = 1 + int'(r[15:8] % 15);
			done_r[n] = 1'b0;
			for (int i = 0; i < cnt; i++) begin
				w = '0;
				if (src_r[n] == SRC_A) begin
					// a short word ends on last and the lanes above stay zero.
					beats = 1 + int'(lcg_next() % PACK);
					for (int k = 0; k < beats; k++) begin
						r = lcg_next();
						beat = NARROW_W'(lcg_next());
						beat[NARROW_W-1 -: 8] = 8'hAA;
						w[k*NARROW_W +: NARROW_W] = beat;
						a_q.push_back(beat);
						a_last_q.push_back(k == beats - 1 && (beats < PACK || r[0]));
					end
				end else begin
					for (int j = 0; j < WIDE_W / 32; j++)
						w[j*32 +: 32] = lcg_next();
					w[WIDE_W-1 -: 8] = (src_r[n] == SRC_C) ? 8'hCC : 8'hDD;
					if (src_r[n] == SRC_C)
						c_q.push_back(w);
					else
						d_q.push_back(w);
				end
				exp_q[n].push_back(w);
			end
		end
		cmd0_src   <= src_r[0];
		cmd0_dst   <= dst_r[0];
		cmd0_count <= CNT_W'(exp_q[0].size());
		cmd0_valid <= 1'b1;
		cmd1_src   <= src_r[1];
		cmd1_dst   <= dst_r[1];
		cmd1_count <= CNT_W'(exp_q[1].size());
		cmd1_valid <= 1'b1;
		while (!(done_r[0] && done_r[1] && exp_q[0].size() == 0 && exp_q[1].size() == 0))
			next_cycle();
		repeat (2) next_cycle();
	endtask

	initial begin
		#(ROUNDS * 64 * CLK_PERIOD);
		$display("timeout: the routing rounds did not finish in time");
		stop_run();
	end

	initial begin
		rng_state   = 32'd89;
		err_cnt     = 0;
		clk         = 1'b0;
		rst_n       = 1'b1;
		in_a_data   = '0;
		in_a_valid  = 1'b0;
		in_a_last   = 1'b0;
		in_c_data   = '0;
		in_c_valid  = 1'b0;
		in_d_data   = '0;
		in_d_valid  = 1'b0;
		cmd0_src    = SRC_A;
		cmd0_dst    = DST_X;
		cmd0_count  = '0;
		cmd0_valid  = 1'b0;
		cmd1_src    = SRC_A;
		cmd1_dst    = DST_X;
		cmd1_count  = '0;
		cmd1_valid  = 1'b0;
		out_x_ready = 1'b0;
		out_y_ready = 1'b0;
		for (int n = 0; n < 2; n++) begin
			src_r[n]     = SRC_A;
			dst_r[n]     = DST_X;
			done_r[n]    = 1'b1;
			ready_due[n] = 1'b0;
		end
		repeat (8) @(posedge clk);
		rst_n <= 1'b0;
		@(posedge clk);
		check_flag("out_x_valid", out_x_valid, 1'b0);
		check_flag("out_y_valid", out_y_valid, 1'b0);
		check_flag("cmd0_done", cmd0_done, 1'b0);
		check_flag("cmd1_done", cmd1_done, 1'b0);
		check_flag("cmd0_ready", cmd0_ready, 1'b1);
		check_flag("cmd1_ready", cmd1_ready, 1'b1);
		for (int i = 0; i < ROUNDS; i++)
			run_round();
		if (err_cnt == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			stop_run();
		end
	end

endmodule

//--- sim.f
droute_cfg_pkg.sv
droute_cmd_pkg.sv
beat_packer.sv
route_fsm.sv
word_counter.sv
route_switch.sv
stream_merge.sv
droute.sv
droute_tb_assert.sv
droute_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -sv -f sim.f --top-module droute_tb -o droute_sim

./obj_dir/droute_sim | tee sim.log

if grep -q "All checks passed" sim.log; then
	echo "simulation PASS"
else
	echo "simulation FAIL"
	exit 1
fi
